/* rtl/exe_op_pkg.sv */
package exe_op_pkg;

    // alu operation select
    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_MUL  = 4'd10;

    // conditional branch compares
    localparam int BR_W = 3;

    localparam logic [BR_W-1:0] BR_NONE = 3'd0;
    localparam logic [BR_W-1:0] BR_EQ   = 3'd1;
    localparam logic [BR_W-1:0] BR_NE   = 3'd2;
    localparam logic [BR_W-1:0] BR_LT   = 3'd3;
    localparam logic [BR_W-1:0] BR_GE   = 3'd4;
    localparam logic [BR_W-1:0] BR_LTU  = 3'd5;
    localparam logic [BR_W-1:0] BR_GEU  = 3'd6;

    // access size of a load or store
    localparam logic [1:0] MEM_NONE = 2'd0;
    localparam logic [1:0] MEM_B    = 2'd1;
    localparam logic [1:0] MEM_H    = 2'd2;
    localparam logic [1:0] MEM_W    = 2'd3;

endpackage

/* rtl/exe_mem_pkg.sv */
package exe_mem_pkg;

    // data sram size field
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;

    // exception codes
    localparam int ECODE_W = 8;

    localparam logic [ECODE_W-1:0] ECODE_NONE = 8'h00;
    localparam logic [ECODE_W-1:0] ECODE_ALE  = 8'h09;

endpackage

/* rtl/exe_mem_if.sv */
`timescale 1ns/100ps

interface exe_mem_if;

    // from the stage core
    logic        act;
    logic        is_store;
    logic [1:0]  size;
    logic [31:0] addr;
    logic [31:0] wdata;

    // back from the request unit
    logic        ale;
    logic        done;
    logic        busy;

    modport core (
        output act, is_store, size, addr, wdata,
        input  ale, done, busy
    );

    modport lsu (
        input  act, is_store, size, addr, wdata,
        output ale, done, busy
    );

endinterface

/* rtl/exe_alu.sv */
`timescale 1ns/100ps

module exe_alu #(
    parameter int MUL_CYCLES = 3
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [exe_op_pkg::ALU_OP_W-1:0] op,
    input  logic [31:0]                     src1,
    input  logic [31:0]                     src2,
    output logic [31:0]                     result,
    output logic                            stall
);

    localparam int CNT_W = $clog2(MUL_CYCLES);

    logic             mul_op;
    logic [CNT_W-1:0] cnt;
    logic [31:0]      sum;
    logic [31:0]      diff;
    logic [31:0]      mul_lo;

    assign mul_op = (op == exe_op_pkg::ALU_MUL);
    assign sum    = src1 + src2;
    assign diff   = src1 - src2;
    // low word only, same for signed and unsigned
    assign mul_lo = src1 * src2;

    // reloads whenever another op sits in the stage
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt <= CNT_W'(MUL_CYCLES - 1);
        end
        else if (!mul_op) begin
            cnt <= CNT_W'(MUL_CYCLES - 1);
        end
        else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign stall = mul_op && (cnt != '0);

    always_comb begin
        case (op)
            exe_op_pkg::ALU_SUB:  result = diff;
            exe_op_pkg::ALU_SLT:  result = {31'd0, $signed(src1) < $signed(src2)};
            exe_op_pkg::ALU_SLTU: result = {31'd0, src1 < src2};
            exe_op_pkg::ALU_AND:  result = src1 & src2;
            exe_op_pkg::ALU_OR:   result = src1 | src2;
            exe_op_pkg::ALU_XOR:  result = src1 ^ src2;
            exe_op_pkg::ALU_SLL:  result = src1 << src2[4:0];
            exe_op_pkg::ALU_SRL:  result = src1 >> src2[4:0];
            exe_op_pkg::ALU_SRA:  result = $signed(src1) >>> src2[4:0];
            exe_op_pkg::ALU_MUL:  result = mul_lo;
            default:              result = sum;
        endcase
    end

endmodule

/* rtl/exe_branch.sv */
`timescale 1ns/100ps

module exe_branch (
    input  logic                        valid,
    input  logic [exe_op_pkg::BR_W-1:0] cond,
    input  logic [31:0]                 src1,
    input  logic [31:0]                 src2,
    input  logic [31:0]                 pc,
    input  logic [31:0]                 target,
    input  logic [31:0]                 pred_target,
    input  logic                        pred_taken,
    output logic                        mispredict,
    output logic [31:0]                 redirect_pc
);

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    assign eq  = (src1 == src2);
    assign lt  = $signed(src1) < $signed(src2);
    assign ltu = src1 < src2;

    always_comb begin
        case (cond)
            exe_op_pkg::BR_EQ:  taken = eq;
            exe_op_pkg::BR_NE:  taken = !eq;
            exe_op_pkg::BR_LT:  taken = lt;
            exe_op_pkg::BR_GE:  taken = !lt;
            exe_op_pkg::BR_LTU: taken = ltu;
            exe_op_pkg::BR_GEU: taken = !ltu;
            default:            taken = 1'b0;
        endcase
    end

    // wrong direction, or right direction to the wrong place
    assign mispredict  = valid && ((taken != pred_taken) || (taken && target != pred_target));
    assign redirect_pc = taken ? target : pc + 32'd4;

endmodule

/* rtl/exe_lsu_req.sv */
`timescale 1ns/100ps

module exe_lsu_req (
    input  logic        clk,
    input  logic        rstn,
    exe_mem_if.lsu      mem,
    output logic        data_sram_req,
    output logic        data_sram_wr,
    output logic [1:0]  data_sram_size,
    output logic [3:0]  data_sram_wstrb,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic        data_sram_addr_ok,
    input  logic        data_sram_data_ok
);

    logic       misaligned;
    logic       new_req;
    logic       req_hold;
    logic       accepted;
    logic       outstanding;
    logic [3:0] strobe;

    assign misaligned = (mem.size == exe_op_pkg::MEM_H && mem.addr[0]) ||
                        (mem.size == exe_op_pkg::MEM_W && mem.addr[1:0] != 2'b00);
    assign mem.ale    = mem.act && misaligned;

    assign new_req       = mem.act && !misaligned && !accepted;
    // once raised, req stays up until the address is taken
    assign data_sram_req = new_req || req_hold;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_hold    <= 1'b0;
            accepted    <= 1'b0;
            outstanding <= 1'b0;
        end
        else begin
            req_hold <= data_sram_req && !data_sram_addr_ok;
            if (!mem.act) begin
                accepted <= 1'b0;
            end
            else if (data_sram_req && data_sram_addr_ok) begin
                accepted <= 1'b1;
            end
            if (data_sram_data_ok) begin
                outstanding <= 1'b0;
            end
            else if (data_sram_req && data_sram_addr_ok) begin
                outstanding <= 1'b1;
            end
        end
    end

    assign mem.done = accepted || (data_sram_req && data_sram_addr_ok);
    assign mem.busy = (outstanding || data_sram_req) && !data_sram_data_ok;

    // lane formatting
    always_comb begin
        case (mem.size)
            exe_op_pkg::MEM_B: begin
                strobe          = 4'b0001 << mem.addr[1:0];
                data_sram_size  = exe_mem_pkg::SIZE_B;
                data_sram_wdata = {4{mem.wdata[7:0]}};
            end
            exe_op_pkg::MEM_H: begin
                strobe          = mem.addr[1] ? 4'b1100 : 4'b0011;
                data_sram_size  = exe_mem_pkg::SIZE_H;
                data_sram_wdata = {2{mem.wdata[15:0]}};
            end
            default: begin
                strobe          = 4'b1111;
                data_sram_size  = exe_mem_pkg::SIZE_W;
                data_sram_wdata = mem.wdata;
            end
        endcase
    end

    assign data_sram_wstrb = mem.is_store ? strobe : 4'b0000;
    assign data_sram_wr    = mem.is_store;
    assign data_sram_addr  = mem.addr;

endmodule

/* rtl/exe_top.sv */
`timescale 1ns/100ps

module exe_top #(
    parameter int MUL_CYCLES = 3
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [31:0]                        in_pc,
    input  logic [exe_op_pkg::ALU_OP_W-1:0]    in_alu_op,
    input  logic [31:0]                        in_src1,
    input  logic [31:0]                        in_src2,
    input  logic [31:0]                        in_store_data,
    input  logic [1:0]                         in_mem_size,
    input  logic                               in_is_store,
    input  logic [4:0]                         in_dest,
    input  logic                               in_gr_we,
    input  logic [exe_op_pkg::BR_W-1:0]        in_br_cond,
    input  logic [31:0]                        in_br_target,
    input  logic                               in_pred_taken,
    input  logic [31:0]                        in_pred_target,
    input  logic                               in_ex,
    input  logic [exe_mem_pkg::ECODE_W-1:0]    in_ecode,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic [31:0]                        out_pc,
    output logic [31:0]                        out_result,
    output logic [4:0]                         out_dest,
    output logic                               out_gr_we,
    output logic                               out_is_load,
    output logic [1:0]                         out_mem_size,
    output logic                               out_ex,
    output logic [exe_mem_pkg::ECODE_W-1:0]    out_ecode,
    input  logic                               flush,
    output logic                               redirect_valid,
    output logic [31:0]                        redirect_pc,
    output logic                               data_sram_req,
    output logic                               data_sram_wr,
    output logic [1:0]                         data_sram_size,
    output logic [3:0]                         data_sram_wstrb,
    output logic [31:0]                        data_sram_addr,
    output logic [31:0]                        data_sram_wdata,
    input  logic                               data_sram_addr_ok,
    input  logic                               data_sram_data_ok
);

    logic                            valid;
    logic                            ex_flag;
    logic [31:0]                     pc_q;
    logic [exe_op_pkg::ALU_OP_W-1:0] alu_op_q;
    logic [31:0]                     src1_q;
    logic [31:0]                     src2_q;
    logic [31:0]                     store_data_q;
    logic [1:0]                      mem_size_q;
    logic                            is_store_q;
    logic [4:0]                      dest_q;
    logic                            gr_we_q;
    logic [exe_op_pkg::BR_W-1:0]     br_cond_q;
    logic [31:0]                     br_target_q;
    logic                            pred_taken_q;
    logic [31:0]                     pred_target_q;
    logic                            in_ex_q;
    logic [exe_mem_pkg::ECODE_W-1:0] ecode_q;

    logic [exe_op_pkg::ALU_OP_W-1:0] alu_op;
    logic [31:0]                     alu_result;
    logic                            alu_stall;
    logic                            ready_go;
    logic                            slot_hold;
    logic                            ex_now;
    logic                            mispredict;

    exe_mem_if mem_bus ();

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            pc_q          <= in_pc;
            alu_op_q      <= in_alu_op;
            src1_q        <= in_src1;
            src2_q        <= in_src2;
            store_data_q  <= in_store_data;
            mem_size_q    <= in_mem_size;
            is_store_q    <= in_is_store;
            dest_q        <= in_dest;
            gr_we_q       <= in_gr_we;
            br_cond_q     <= in_br_cond;
            br_target_q   <= in_br_target;
            pred_taken_q  <= in_pred_taken;
            pred_target_q <= in_pred_target;
            in_ex_q       <= in_ex;
            ecode_q       <= in_ecode;
        end
    end

    // younger work enters as a bubble after an exception or a redirect
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= 1'b0;
        end
        else if (flush) begin
            valid <= 1'b0;
        end
        else if (in_ready) begin
            valid <= in_valid && !ex_flag && !ex_now && !mispredict;
        end
        else if (out_valid && out_ready) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex_flag <= 1'b0;
        end
        else if (flush) begin
            ex_flag <= 1'b0;
        end
        else if (ex_now) begin
            ex_flag <= 1'b1;
        end
    end

    assign alu_op = valid ? alu_op_q : exe_op_pkg::ALU_ADD;

    exe_alu #(
        .MUL_CYCLES (MUL_CYCLES)
    ) u_alu (
        .clk    (clk),
        .rstn   (rstn),
        .op     (alu_op),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result),
        .stall  (alu_stall)
    );

    exe_branch u_branch (
        .valid       (valid),
        .cond        (br_cond_q),
        .src1        (src1_q),
        .src2        (src2_q),
        .pc          (pc_q),
        .target      (br_target_q),
        .pred_target (pred_target_q),
        .pred_taken  (pred_taken_q),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc)
    );

    assign mem_bus.act      = valid && !in_ex_q && (mem_size_q != exe_op_pkg::MEM_NONE);
    assign mem_bus.is_store = is_store_q;
    assign mem_bus.size     = mem_size_q;
    assign mem_bus.addr     = alu_result;
    assign mem_bus.wdata    = store_data_q;

    exe_lsu_req u_lsu (
        .clk               (clk),
        .rstn              (rstn),
        .mem               (mem_bus),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok),
        .data_sram_data_ok (data_sram_data_ok)
    );

    assign ready_go = !alu_stall && (!mem_bus.act || mem_bus.ale || mem_bus.done);
    // multiply and memory ops leave one empty cycle behind them
    assign slot_hold = (alu_op_q == exe_op_pkg::ALU_MUL) || mem_bus.act;
    assign in_ready  = !mem_bus.busy && (!valid || (ready_go && out_ready && !slot_hold));
    assign out_valid = valid && ready_go;

    assign ex_now    = valid && (in_ex_q || mem_bus.ale);
    assign out_ex    = ex_now;
    assign out_ecode = !ex_now ? exe_mem_pkg::ECODE_NONE :
                       in_ex_q ? ecode_q : exe_mem_pkg::ECODE_ALE;

    assign out_pc       = pc_q;
    assign out_result   = alu_result;
    assign out_dest     = dest_q;
    assign out_gr_we    = gr_we_q;
    assign out_is_load  = (mem_size_q != exe_op_pkg::MEM_NONE) && !is_store_q;
    assign out_mem_size = mem_size_q;

    assign redirect_valid = mispredict;

endmodule

/* verif/exe_asserts.sv */
`timescale 1ns/100ps

module exe_asserts (
    input logic        clk,
    input logic        rstn,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] out_pc,
    input logic [31:0] out_result,
    input logic        out_ex,
    input logic        flush,
    input logic        redirect_valid,
    input logic        data_sram_req,
    input logic        data_sram_wr,
    input logic [31:0] data_sram_addr,
    input logic        data_sram_addr_ok,
    input logic        data_sram_data_ok
);

    logic pending;
    int   fail_count = 0;

    // address taken, data not back yet
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pending <= 1'b0;
        end
        else if (data_sram_data_ok) begin
            pending <= 1'b0;
        end
        else if (data_sram_req && data_sram_addr_ok) begin
            pending <= 1'b1;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!rstn)
        data_sram_req && !data_sram_addr_ok |=>
            data_sram_req && $stable(data_sram_addr) && $stable(data_sram_wr))
        else begin
            $error("request dropped or changed before addr_ok");
            fail_count++;
        end

    no_accept_while_pending: assert property (@(posedge clk) disable iff (!rstn)
        pending && !data_sram_data_ok |-> !in_ready)
        else begin
            $error("in_ready high with a request outstanding");
            fail_count++;
        end

    hold_under_backpressure: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready && !flush |=>
            out_valid && $stable(out_pc) && $stable(out_result) && $stable(out_ex))
        else begin
            $error("output bundle changed while stalled");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge clk)
        !rstn |=> !out_valid && !redirect_valid && !data_sram_req && in_ready)
        else begin
            $error("stage not idle after reset");
            fail_count++;
        end

endmodule

bind exe_top exe_asserts u_asserts (
    .clk               (clk),
    .rstn              (rstn),
    .in_ready          (in_ready),
    .out_valid         (out_valid),
    .out_ready         (out_ready),
    .out_pc            (out_pc),
    .out_result        (out_result),
    .out_ex            (out_ex),
    .flush             (flush),
    .redirect_valid    (redirect_valid),
    .data_sram_req     (data_sram_req),
    .data_sram_wr      (data_sram_wr),
    .data_sram_addr    (data_sram_addr),
    .data_sram_addr_ok (data_sram_addr_ok),
    .data_sram_data_ok (data_sram_data_ok)
);

/* verif/exe_tb.sv */
`timescale 1ns/100ps

module exe_tb;

    localparam int N_INSTR = 400;

    typedef struct packed {
        logic [31:0]                     pc;
        logic [31:0]                     result;
        logic [4:0]                      dest;
        logic                            gr_we;
        logic                            is_load;
        logic [1:0]                      mem_size;
        logic                            ex;
        logic [exe_mem_pkg::ECODE_W-1:0] ecode;
        logic                            redirect;
        logic [31:0]                     redirect_pc;
    } out_exp_t;

    typedef struct packed {
        logic        wr;
        logic [1:0]  size;
        logic [3:0]  wstrb;
        logic [31:0] addr;
        logic [31:0] wdata;
    } req_exp_t;

    logic clk, rstn, in_valid, in_ready, in_is_store, in_gr_we, in_pred_taken, in_ex;
    logic [31:0] in_pc, in_src1, in_src2, in_store_data, in_br_target, in_pred_target;
    logic [exe_op_pkg::ALU_OP_W-1:0] in_alu_op;
    logic [exe_op_pkg::BR_W-1:0]     in_br_cond;
    logic [1:0]                      in_mem_size;
    logic [4:0]                      in_dest;
    logic [exe_mem_pkg::ECODE_W-1:0] in_ecode;
    logic out_valid, out_ready, out_gr_we, out_is_load, out_ex, flush, redirect_valid;
    logic [31:0] out_pc, out_result, redirect_pc;
    logic [4:0]                      out_dest;
    logic [1:0]                      out_mem_size;
    logic [exe_mem_pkg::ECODE_W-1:0] out_ecode;
    logic data_sram_req, data_sram_wr, data_sram_addr_ok, data_sram_data_ok;
    logic [1:0]  data_sram_size;
    logic [3:0]  data_sram_wstrb;
    logic [31:0] data_sram_addr, data_sram_wdata;

    out_exp_t exp_q[$];
    req_exp_t req_q[$];
    int       errors;
    int       checks;
    logic     ex_mode;
    logic     drop_next;
    int       ex_left;

    exe_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [63:0] prod;
        logic [4:0]  sh;
        prod = {32'd0, a} * {32'd0, b};
        sh = b[4:0];
        case (op)
            exe_op_pkg::ALU_SUB:  return a - b;
            exe_op_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_op_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            exe_op_pkg::ALU_AND:  return a & b;
            exe_op_pkg::ALU_OR:   return a | b;
            exe_op_pkg::ALU_XOR:  return a ^ b;
            exe_op_pkg::ALU_SLL:  return a << sh;
            exe_op_pkg::ALU_SRL:  return a >> sh;
            // sign bits filled in from the top
            exe_op_pkg::ALU_SRA:  return ({32{a[31]}} & ~(32'hffff_ffff >> sh)) | (a >> sh);
            exe_op_pkg::ALU_MUL:  return prod[31:0];
            default:              return a + b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] cond, input logic [31:0] a,
                                          input logic [31:0] b);
        logic slt;
        slt = (a[31] != b[31]) ? a[31] : (a < b);
        case (cond)
            exe_op_pkg::BR_EQ:  return a == b;
            exe_op_pkg::BR_NE:  return a != b;
            exe_op_pkg::BR_LT:  return slt;
            exe_op_pkg::BR_GE:  return !slt;
            exe_op_pkg::BR_LTU: return a < b;
            exe_op_pkg::BR_GEU: return a >= b;
            default:            return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] lanes(input logic [1:0] size, input logic [1:0] off);
        int         nbytes;
        logic [3:0] m;
        nbytes = (size == exe_op_pkg::MEM_B) ? 1 : (size == exe_op_pkg::MEM_H) ? 2 : 4;
        for (int i = 0; i < 4; i++) begin
            m[i] = (i >= int'(off)) && (i < int'(off) + nbytes);
        end
        return m;
    endfunction

    task automatic pick_instr(input int idx);
        int         kind;
        logic [1:0] off;
        kind = $urandom_range(19, 0);
        in_pc = 32'h1c00_0000 + 32'(idx) * 32'd4;
        in_alu_op = 4'($urandom_range(9, 0));
        in_src1 = $urandom();
        in_src2 = $urandom();
        in_store_data = $urandom();
        in_dest = 5'($urandom_range(31, 0));
        in_gr_we = 1'($urandom_range(1, 0));
        in_mem_size = exe_op_pkg::MEM_NONE;
        in_is_store = 1'b0;
        in_br_cond = exe_op_pkg::BR_NONE;
        in_br_target = $urandom() & 32'hffff_fffc;
        in_pred_taken = 1'b0;
        in_pred_target = 32'd0;
        in_ex = 1'b0;
        in_ecode = '0;
        if (kind < 3) begin
            in_alu_op = exe_op_pkg::ALU_MUL;
        end
        else if (kind < 7) begin
            in_br_cond = 3'($urandom_range(6, 1));
            in_pred_taken = 1'($urandom_range(1, 0));
            in_pred_target = ($urandom_range(1, 0) == 0) ? in_br_target : in_br_target + 32'd4;
            if ($urandom_range(1, 0) == 0) in_src2 = in_src1;
        end
        else if (kind < 13) begin
            in_alu_op = exe_op_pkg::ALU_ADD;
            in_mem_size = 2'($urandom_range(3, 1));
            in_is_store = 1'($urandom_range(1, 0));
            off = 2'($urandom_range(3, 0));
            // mostly aligned, sometimes not
            if ($urandom_range(5, 0) != 0) begin
                if (in_mem_size == exe_op_pkg::MEM_W) off = 2'b00;
                if (in_mem_size == exe_op_pkg::MEM_H) off[0] = 1'b0;
            end
            in_src1 = $urandom() & 32'hffff_fff0;
            in_src2 = 32'(off) + (32'($urandom_range(63, 0)) << 2);
        end
        else if (kind == 13) begin
            in_ex = 1'b1;
            in_ecode = 8'($urandom_range(255, 1));
        end
    endtask

    task automatic record_accept();
        out_exp_t e;
        req_exp_t r;
        logic     taken;
        logic     misaligned;
        if (ex_mode) begin
            ex_left--;
        end
        else if (drop_next) begin
            drop_next = 1'b0;
        end
        else begin
            e.pc = in_pc;
            e.result = alu_ref(in_alu_op, in_src1, in_src2);
            e.dest = in_dest;
            e.gr_we = in_gr_we;
            e.is_load = (in_mem_size != exe_op_pkg::MEM_NONE) && !in_is_store;
            e.mem_size = in_mem_size;
            misaligned = (in_mem_size == exe_op_pkg::MEM_H && e.result[0]) ||
                         (in_mem_size == exe_op_pkg::MEM_W && e.result[1:0] != 2'b00);
            e.ex = in_ex || misaligned;
            e.ecode = in_ex ? in_ecode :
                      misaligned ? exe_mem_pkg::ECODE_ALE : exe_mem_pkg::ECODE_NONE;
            taken = branch_taken(in_br_cond, in_src1, in_src2);
            e.redirect = (taken != in_pred_taken) || (taken && in_br_target != in_pred_target);
            e.redirect_pc = taken ? in_br_target : in_pc + 32'd4;
            exp_q.push_back(e);
            if (in_mem_size != exe_op_pkg::MEM_NONE && !in_ex && !misaligned) begin
                r.wr = in_is_store;
                r.addr = e.result;
                r.size = (in_mem_size == exe_op_pkg::MEM_B) ? exe_mem_pkg::SIZE_B :
                         (in_mem_size == exe_op_pkg::MEM_H) ? exe_mem_pkg::SIZE_H :
                         exe_mem_pkg::SIZE_W;
                r.wstrb = lanes(in_mem_size, e.result[1:0]);
                r.wdata = (in_mem_size == exe_op_pkg::MEM_B) ? {4{in_store_data[7:0]}} :
                          (in_mem_size == exe_op_pkg::MEM_H) ? {2{in_store_data[15:0]}} :
                          in_store_data;
                req_q.push_back(r);
            end
            if (e.ex) begin
                ex_mode = 1'b1;
                ex_left = $urandom_range(3, 1);
            end
            drop_next = e.redirect;
        end
    endtask

    // stage is empty once every expected output has left
    task automatic flush_stage();
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        ex_mode = 1'b0;
        drop_next = 1'b0;
    endtask

    initial begin : stimulus
        errors = 0;
        checks = 0;
        ex_mode = 1'b0;
        drop_next = 1'b0;
        ex_left = 0;
        void'($urandom(51));
        rstn = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        pick_instr(0);
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < N_INSTR; i++) begin
            @(negedge clk);
            pick_instr(i);
            in_valid = 1'b1;
            do @(posedge clk); while (!in_ready);
            record_accept();
            if (ex_mode && ex_left == 0) flush_stage();
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0 || req_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        errors += dut.u_asserts.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end
        else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin : output_check
        out_exp_t e;
        if (rstn && out_valid && out_ready) begin
            checks++;
            assert (exp_q.size() != 0)
                else report_mismatch($sformatf("unexpected output, pc %h", out_pc));
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (out_pc == e.pc && out_result == e.result)
                    else report_mismatch($sformatf("pc %h result %h, expected pc %h result %h",
                                                   out_pc, out_result, e.pc, e.result));
                assert ({out_dest, out_gr_we, out_is_load, out_mem_size} ==
                        {e.dest, e.gr_we, e.is_load, e.mem_size})
                    else report_mismatch($sformatf("pc %h wrong dest or memory bundle", e.pc));
                assert (out_ex == e.ex && out_ecode == e.ecode)
                    else report_mismatch($sformatf("pc %h ex %b ecode %h, expected %b %h",
                                                   e.pc, out_ex, out_ecode, e.ex, e.ecode));
                assert (redirect_valid == e.redirect &&
                        (!e.redirect || redirect_pc == e.redirect_pc))
                    else report_mismatch($sformatf("pc %h redirect %b %h, expected %b %h", e.pc,
                                                   redirect_valid, redirect_pc, e.redirect,
                                                   e.redirect_pc));
            end
        end
    end

    always @(posedge clk) begin : request_check
        req_exp_t r;
        if (rstn && data_sram_req && data_sram_addr_ok) begin
            checks++;
            assert (req_q.size() != 0)
                else report_mismatch($sformatf("unexpected request, addr %h", data_sram_addr));
            if (req_q.size() != 0) begin
                r = req_q.pop_front();
                assert (data_sram_wr == r.wr && data_sram_addr == r.addr &&
                        data_sram_size == r.size)
                    else report_mismatch($sformatf(
                        "request wr %b addr %h size %0d, expected %b %h %0d",
                        data_sram_wr, data_sram_addr, data_sram_size, r.wr, r.addr, r.size));
                assert (!r.wr || (data_sram_wstrb == r.wstrb && data_sram_wdata == r.wdata))
                    else report_mismatch($sformatf("store strobe %b data %h, expected %b %h",
                                                   data_sram_wstrb, data_sram_wdata,
                                                   r.wstrb, r.wdata));
            end
        end
    end

    initial begin : backpressure
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            out_ready = ($urandom_range(3, 0) != 0);
        end
    end

    initial begin : sram_responder
        int d;
        data_sram_addr_ok = 1'b0;
        data_sram_data_ok = 1'b0;
        forever begin
            @(negedge clk);
            if (rstn && data_sram_req) begin
                d = $urandom_range(3, 0);
                repeat (d) @(negedge clk);
                data_sram_addr_ok = 1'b1;
                @(negedge clk);
                data_sram_addr_ok = 1'b0;
                d = $urandom_range(2, 0);
                repeat (d) @(negedge clk);
                data_sram_data_ok = 1'b1;
                @(negedge clk);
                data_sram_data_ok = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = N_INSTR * (dut.MUL_CYCLES + 8);
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("checks %0d, errors %0d", checks, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* all.f */
rtl/exe_op_pkg.sv
rtl/exe_mem_pkg.sv
rtl/exe_mem_if.sv
rtl/exe_alu.sv
rtl/exe_branch.sv
rtl/exe_lsu_req.sv
rtl/exe_top.sv
verif/exe_asserts.sv
verif/exe_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exe_tb -f all.f -o exe_sim

result=$(./obj_dir/exe_sim)
echo "$result"

echo "$result" | grep -qx "ALL TESTS PASSED"
